// ==== hw/apb_pkg.sv ====
// APB bus types and widths
`default_nettype none

package apb_pkg;

	// ******************************
	// Widths
	// ******************************

	// Byte address, 64 KB space
	localparam int addr_w = 16;
	// One data word
	localparam int data_w = 32;
	// Peripheral wait-state counter, up to 15 cycles
	localparam int wait_w = 4;

	// ******************************
	// Handshake payloads
	// ******************************

	// One command from the host side
	typedef struct packed {
		logic              write;
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] wdata;
	} apb_cmd_t;

	// One response back to the host side
	typedef struct packed {
		logic [data_w-1:0] rdata;
		logic              slverr;
		// Echo of the command direction
		logic              write;
	} apb_rsp_t;

	// ******************************
	// APB signal bundles
	// ******************************

	// Master to slave
	typedef struct packed {
		logic              sel;
		logic              enable;
		logic              write;
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] wdata;
	} apb_req_t;

	// Slave to master
	typedef struct packed {
		logic [data_w-1:0] rdata;
		logic              ready;
		logic              slverr;
	} apb_resp_t;

endpackage

`default_nettype wire

// ==== hw/map_pkg.sv ====
// Peripheral address map
`default_nettype none

package map_pkg;

	// ******************************
	// Slave select
	// ******************************

	// Three register banks on the bus
	localparam int num_slaves = 3;
	// Select field is addr[15:12]
	localparam int sel_hi = 15;
	localparam int sel_w = 4;

	// Base address per slave, entry 0 is bank 0
	// Only the select field takes part in the compare
	localparam logic [num_slaves-1:0][apb_pkg::addr_w-1:0] base_addr = {
		16'h2000,
		16'h1000,
		16'h0000
	};

	// ******************************
	// Register bank layout
	// ******************************

	// Eight words per bank
	localparam int reg_count = 8;
	// Word offset starts above the byte lanes
	localparam int off_lo = 2;
	// Index bits, the bit above them flags offsets 8 to 15
	localparam int idx_w = $clog2(reg_count);

endpackage

`default_nettype wire

// ==== hw/apb_queue.sv ====
// Two-entry valid/ready FIFO
`default_nettype none

module apb_queue #(
	parameter type payload_t = logic
) (
	input  wire      clk,
	input  wire      rst_n,
	input  wire      in_valid,
	output logic     in_ready,
	input  wire      payload_t in_data,
	output logic     out_valid,
	input  wire      out_ready,
	output payload_t out_data
);

	// Storage and pointers
	payload_t   mem [2];
	logic       wr_ptr;
	logic       rd_ptr;
	// Occupancy from 0 to 2
	logic [1:0] count;
	logic       push;
	logic       pop;

	// ******************************
	// Handshakes
	// ******************************

	// Full only at two entries
	assign in_ready  = (count != 2'd2);
	assign push      = in_valid && in_ready;
	// Output comes from registered storage so a push shows up a cycle later
	assign out_valid = (count != 2'd0);
	assign pop       = out_valid && out_ready;
	assign out_data  = mem[rd_ptr];

	// ******************************
	// Pointers and count
	// ******************************

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count  <= 2'd0;
		end
		else
		begin
			// One-bit pointers wrap by themselves
			if (push)
				wr_ptr <= ~wr_ptr;
			if (pop)
				rd_ptr <= ~rd_ptr;
			// Push and pop together leave the count alone
			case ({push, pop})
				2'b10: count <= count + 2'd1;
				2'b01: count <= count - 2'd1;
				default: count <= count;
			endcase
		end
	end

	// Payload write
	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= in_data;
	end

	// Head entry holds while the reader stalls, so no push lands on it
	a_head_stable: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

// ==== hw/apb_regbank.sv ====
// APB register bank peripheral
`default_nettype none

module apb_regbank #(
	parameter int unsigned WAIT_STATES = 0
) (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                apb_pkg::apb_req_t req,
	output apb_pkg::apb_resp_t resp
);

	import apb_pkg::*;
	import map_pkg::*;

	// Register file
	logic [data_w-1:0] regs [reg_count];
	// Word index and the out-of-range flag above it
	logic [idx_w-1:0]  idx;
	logic              unused_off;
	// Selected and in ACCESS
	logic              access;
	logic [wait_w-1:0] wait_cnt;
	logic              ready;

	// ******************************
	// Decode and wait states
	// ******************************

	assign idx        = req.addr[off_lo +: idx_w];
	// Offsets 8 to 15
	assign unused_off = req.addr[off_lo + idx_w];
	assign access     = req.sel && req.enable;
	// Counter reaches the set count on the last ACCESS cycle
	assign ready      = access && (wait_cnt == wait_w'(WAIT_STATES));

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			wait_cnt <= '0;
		else if (access && !ready)
			wait_cnt <= wait_cnt + 1'b1;
		else
			wait_cnt <= '0;
	end

	// ******************************
	// Register write
	// ******************************

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < reg_count; i++)
			begin
				regs[i] <= '0;
			end
		end
		// Store only on the completion edge, never for unused offsets
		else if (ready && req.write && !unused_off)
		begin
			regs[idx] <= req.wdata;
		end
	end

	// Read data and status
	always_comb
	begin
		resp.ready  = ready;
		resp.slverr = ready && unused_off;
		// Writes and errors return zero
		resp.rdata  = (access && !req.write && !unused_off) ? regs[idx] : '0;
	end

	// ACCESS length is WAIT_STATES + 1
	a_wait_len: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(access) |-> ##WAIT_STATES ready);

endmodule

`default_nettype wire

// ==== hw/apb_bus.sv ====
// APB decoder and response mux
`default_nettype none

module apb_bus (
	input  wire                                         clk,
	input  wire                                         rst_n,
	input  wire                                         apb_pkg::apb_req_t m_req,
	output apb_pkg::apb_resp_t                          m_resp,
	output apb_pkg::apb_req_t [map_pkg::num_slaves-1:0] s_req,
	input  wire apb_pkg::apb_resp_t [map_pkg::num_slaves-1:0] s_resp
);

	import map_pkg::*;

	// Raw compare per slave
	logic [num_slaves-1:0] match;
	// Compare qualified by sel
	logic [num_slaves-1:0] hit;
	// Unmapped access seen in SETUP
	logic                  miss_q;

	// ******************************
	// Address decode
	// ******************************

	always_comb
	begin
		for (int i = 0; i < num_slaves; i++)
		begin
			match[i] = (m_req.addr[sel_hi -: sel_w] == base_addr[i][sel_hi -: sel_w]);
		end
	end

	// Idle bus selects nobody
	assign hit = match & {num_slaves{m_req.sel}};

	// Broadcast everything but sel
	always_comb
	begin
		for (int i = 0; i < num_slaves; i++)
		begin
			s_req[i]     = m_req;
			s_req[i].sel = hit[i];
		end
	end

	// ******************************
	// Default slave
	// ******************************

	// Set in SETUP of an unmapped transfer, so ACCESS completes at once
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			miss_q <= 1'b0;
		else
			miss_q <= m_req.sel && !m_req.enable && (hit == '0);
	end

	// ******************************
	// Response mux
	// ******************************

	always_comb
	begin
		// Nothing hit gives zero data
		m_resp = '0;
		for (int i = 0; i < num_slaves; i++)
		begin
			if (hit[i])
				m_resp = s_resp[i];
		end
		// Error completion for the unmapped case
		if (miss_q)
		begin
			m_resp.ready  = m_req.enable;
			m_resp.slverr = 1'b1;
		end
	end

	// Base addresses must not overlap
	a_hit_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(hit));

endmodule

`default_nettype wire

// ==== hw/apb_master.sv ====
// APB master sequencer
`default_nettype none

module apb_master (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                cmd_valid,
	output logic               cmd_ready,
	input  wire                apb_pkg::apb_cmd_t cmd,
	output logic               rsp_valid,
	input  wire                rsp_ready,
	output apb_pkg::apb_rsp_t  rsp,
	output apb_pkg::apb_req_t  apb_req,
	input  wire                apb_pkg::apb_resp_t apb_resp
);

	import apb_pkg::*;

	// Transfer phases
	typedef enum logic [1:0] {
		st_idle,
		st_setup,
		st_access
	} state_t;

	state_t   state;
	// Command under transfer, held until completion
	apb_cmd_t cur_cmd;
	logic     accept;
	logic     done;

	// ******************************
	// Command intake
	// ******************************

	// Idle and a free response slot
	// Skip the cycle where the previous response is still being pushed,
	// its slot is not yet counted by the response queue
	assign cmd_ready = (state == st_idle) && rsp_ready && !rsp_valid;
	assign accept    = cmd_valid && cmd_ready;
	// Completion edge of ACCESS
	assign done      = (state == st_access) && apb_resp.ready;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= st_idle;
			rsp_valid <= 1'b0;
		end
		else
		begin
			// Response pulse lasts one cycle
			rsp_valid <= done;
			case (state)
				st_idle:
				begin
					if (accept)
						state <= st_setup;
				end
				// SETUP is always a single cycle
				st_setup:
				begin
					state <= st_access;
				end
				st_access:
				begin
					if (apb_resp.ready)
						state <= st_idle;
				end
				default:
				begin
					state <= st_idle;
				end
			endcase
		end
	end

	// Payload capture
	always_ff @(posedge clk)
	begin
		if (accept)
			cur_cmd <= cmd;
		if (done)
			rsp <= '{rdata: apb_resp.rdata, slverr: apb_resp.slverr, write: cur_cmd.write};
	end

	// ******************************
	// APB request
	// ******************************

	always_comb
	begin
		apb_req.sel    = (state != st_idle);
		apb_req.enable = (state == st_access);
		// Fields come from the latched command so they stay put in ACCESS
		apb_req.write  = cur_cmd.write;
		apb_req.addr   = cur_cmd.addr;
		apb_req.wdata  = cur_cmd.wdata;
	end

	// Protocol checks
	a_enable_sel: assert property (@(posedge clk) disable iff (!rst_n)
		apb_req.enable |-> apb_req.sel);

	a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		apb_req.enable && !apb_resp.ready |=> apb_req.enable && $stable(apb_req));

	// Response queue must have room for every pulse
	a_rsp_space: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid |-> rsp_ready);

endmodule

`default_nettype wire

// ==== hw/apb_subsys_top.sv ====
// APB peripheral subsystem top
`default_nettype none

module apb_subsys_top (
	input  wire               clk,
	input  wire               rst_n,
	input  wire               cmd_valid,
	output logic              cmd_ready,
	input  wire               apb_pkg::apb_cmd_t cmd,
	output logic              rsp_valid,
	input  wire               rsp_ready,
	output apb_pkg::apb_rsp_t rsp
);

	import apb_pkg::*;
	import map_pkg::*;

	// Queue to sequencer
	logic                           q_cmd_valid;
	logic                           q_cmd_ready;
	apb_cmd_t                       q_cmd;
	// Sequencer to response queue
	logic                           m_rsp_valid;
	logic                           m_rsp_ready;
	apb_rsp_t                       m_rsp;
	// APB master side
	apb_req_t                       m_req;
	apb_resp_t                      m_resp;
	// APB slave side, one entry per bank
	apb_req_t [num_slaves-1:0]      s_req;
	wire apb_resp_t [num_slaves-1:0] s_resp;

	// ******************************
	// Command path
	// ******************************

	apb_queue #(.payload_t(apb_cmd_t)) u_cmd_q (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (cmd_valid),
		.in_ready  (cmd_ready),
		.in_data   (cmd),
		.out_valid (q_cmd_valid),
		.out_ready (q_cmd_ready),
		.out_data  (q_cmd)
	);

	apb_master u_master (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd_valid (q_cmd_valid),
		.cmd_ready (q_cmd_ready),
		.cmd       (q_cmd),
		.rsp_valid (m_rsp_valid),
		.rsp_ready (m_rsp_ready),
		.rsp       (m_rsp),
		.apb_req   (m_req),
		.apb_resp  (m_resp)
	);

	// ******************************
	// Bus and peripherals
	// ******************************

	apb_bus u_bus (
		.clk    (clk),
		.rst_n  (rst_n),
		.m_req  (m_req),
		.m_resp (m_resp),
		.s_req  (s_req),
		.s_resp (s_resp)
	);

	// Zero, one and three wait states
	apb_regbank #(.WAIT_STATES(0)) u_bank0 (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (s_req[0]),
		.resp  (s_resp[0])
	);

	apb_regbank #(.WAIT_STATES(1)) u_bank1 (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (s_req[1]),
		.resp  (s_resp[1])
	);

	apb_regbank #(.WAIT_STATES(3)) u_bank2 (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (s_req[2]),
		.resp  (s_resp[2])
	);

	// Response path
	apb_queue #(.payload_t(apb_rsp_t)) u_rsp_q (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (m_rsp_valid),
		.in_ready  (m_rsp_ready),
		.in_data   (m_rsp),
		.out_valid (rsp_valid),
		.out_ready (rsp_ready),
		.out_data  (rsp)
	);

endmodule

`default_nettype wire

// ==== verif/tb_apb_subsys.sv ====
// APB subsystem testbench
`default_nettype none

module tb_apb_subsys;

	import apb_pkg::*;
	import map_pkg::*;

	// Run length and limits
	localparam int clk_period   = 20;
	localparam int reset_cycles = 8;
	localparam int num_rand     = 300;
	// Directed commands in tests 2 to 4
	localparam int num_directed = 24;
	localparam int total_cmds   = num_rand + num_directed;
	localparam int timeout_cycles = total_cmds * 40 + reset_cycles;

	logic     clk;
	logic     rst_n;
	logic     cmd_valid;
	logic     cmd_ready;
	apb_cmd_t cmd;
	logic     rsp_valid;
	logic     rsp_ready;
	apb_rsp_t rsp;

	// Reference state with one row per bank
	logic [data_w-1:0] model [num_slaves][reg_count];
	apb_rsp_t          exp_q [$];
	apb_rsp_t          exp_rsp;
	int                cmd_count;
	int                rsp_count;
	int                errors;
	int                test_errors;

	apb_subsys_top u_apb_subsys_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.cmd       (cmd),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp       (rsp)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(clk_period / 2) clk = ~clk;
	end

	// ******************************
	// Reference model
	// ******************************

	// Expected response for one accepted command and model update on writes
	function automatic apb_rsp_t ref_rsp(input apb_cmd_t c);
		int       bank;
		int       off;
		apb_rsp_t r;
		bank     = int'(c.addr[sel_hi -: sel_w]);
		// Word offset in bits 5..2
		off      = int'(c.addr[5:2]);
		r.write  = c.write;
		r.rdata  = '0;
		r.slverr = 1'b0;
		if (bank >= num_slaves || off >= reg_count)
			r.slverr = 1'b1;
		else if (c.write)
			model[bank][off] = c.wdata;
		else
			r.rdata = model[bank][off];
		return r;
	endfunction

	// Select field, random middle bits, word offset, random byte lanes
	function automatic logic [addr_w-1:0] make_addr(input int sel, input int off);
		logic [5:0] mid;
		logic [1:0] lane;
		mid  = 6'($urandom);
		lane = 2'($urandom);
		return {4'(sel), mid, 4'(off), lane};
	endfunction

	// Accepted commands feed the model
	always @(negedge clk)
	begin
		if (rst_n && cmd_valid && cmd_ready)
		begin
			exp_q.push_back(ref_rsp(cmd));
			cmd_count++;
		end
	end

	// ******************************
	// Comparator
	// ******************************

	always @(negedge clk)
	begin
		if (rst_n && rsp_valid && rsp_ready)
		begin
			rsp_count++;
			assert (exp_q.size() != 0)
			else
			begin
				$display("response at %0t arrived with no command outstanding", $time);
				errors++;
			end
			if (exp_q.size() != 0)
			begin
				exp_rsp = exp_q.pop_front();
				assert (rsp.rdata == exp_rsp.rdata)
				else
				begin
					$display("error: time %0t signal rsp.rdata expected %h actual %h",
						$time, exp_rsp.rdata, rsp.rdata);
					errors++;
				end
				assert (rsp.slverr == exp_rsp.slverr)
				else
				begin
					$display("error: time %0t signal rsp.slverr expected %b actual %b",
						$time, exp_rsp.slverr, rsp.slverr);
					errors++;
				end
				assert (rsp.write == exp_rsp.write)
				else
				begin
					$display("error: time %0t signal rsp.write expected %b actual %b",
						$time, exp_rsp.write, rsp.write);
					errors++;
				end
			end
		end
	end

	// Random back-pressure on the response port with ready in about 5 of 8 cycles
	initial
	begin
		rsp_ready = 1'b0;
		wait (rst_n === 1'b1);
		forever
		begin
			@(posedge clk);
			#2;
			rsp_ready = ($urandom % 8) < 5;
		end
	end

	// ******************************
	// Stimulus tasks
	// ******************************

	// Called 2 units after an edge and returns the same way
	task automatic send_cmd(input logic write, input logic [addr_w-1:0] addr,
		input logic [data_w-1:0] wdata);
		logic taken;
		cmd_valid = 1'b1;
		cmd       = '{write: write, addr: addr, wdata: wdata};
		// Hold until the queue takes it
		do
		begin
			@(negedge clk);
			taken = cmd_ready;
			@(posedge clk);
		end
		while (!taken);
		#2;
		cmd_valid = 1'b0;
	endtask

	// Wait for every outstanding response
	task automatic drain();
		while (exp_q.size() != 0)
		begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic report_test(input string name);
		$display("test %s: %0d errors, %s", name, errors - test_errors,
			(errors == test_errors) ? "passed" : "failed");
		test_errors = errors;
	endtask

	// Watchdog sized from the command count
	initial
	begin
		#(timeout_cycles * clk_period);
		$display("timeout: %0d of %0d responses arrived before the time limit",
			rsp_count, cmd_count);
		$display("Something failed");
		$finish;
	end

	// ******************************
	// Test sequence
	// ******************************

	initial
	begin
		logic [data_w-1:0] val [num_slaves];
		int                sel;
		int                off;
		int                kind;
		void'($urandom(32'hf3a1da71));
		rst_n       = 1'b0;
		cmd_valid   = 1'b0;
		cmd         = '0;
		cmd_count   = 0;
		rsp_count   = 0;
		errors      = 0;
		test_errors = 0;
		for (int b = 0; b < num_slaves; b++)
			for (int r = 0; r < reg_count; r++)
				model[b][r] = '0;
		repeat (reset_cycles) @(posedge clk);
		#2;
		rst_n = 1'b1;

		// Test 1 checks the idle state right after reset
		@(negedge clk);
		assert (cmd_ready === 1'b1)
		else
		begin
			$display("error: time %0t signal cmd_ready expected 1 actual %b", $time, cmd_ready);
			errors++;
		end
		assert (rsp_valid === 1'b0)
		else
		begin
			$display("error: time %0t signal rsp_valid expected 0 actual %b", $time, rsp_valid);
			errors++;
		end
		@(posedge clk);
		#2;
		report_test("1 reset state");

		// Test 2 gives the same register in each bank its own value
		for (int b = 0; b < num_slaves; b++)
		begin
			val[b] = $urandom;
			send_cmd(1'b1, make_addr(b, 5), val[b]);
		end
		for (int b = 0; b < num_slaves; b++)
			send_cmd(1'b0, make_addr(b, 5), $urandom);
		drain();
		report_test("2 bank write and read");

		// Test 3 uses select values without a slave
		foreach (val[i])
		begin
			sel = 3 + 6 * i;
			send_cmd(1'b1, make_addr(sel, i), $urandom);
			send_cmd(1'b0, make_addr(sel, i), $urandom);
		end
		drain();
		report_test("3 unmapped select");

		// Test 4 uses offset 10 as it aliases register 2 in the index bits only
		for (int b = 0; b < num_slaves; b++)
		begin
			send_cmd(1'b1, make_addr(b, 2), $urandom);
			send_cmd(1'b1, make_addr(b, 10), $urandom);
			send_cmd(1'b0, make_addr(b, 10), $urandom);
			send_cmd(1'b0, make_addr(b, 2), $urandom);
		end
		drain();
		report_test("4 unused offsets");

		// Test 5 mixes mapped registers with some error cases
		for (int n = 0; n < num_rand; n++)
		begin
			kind = $urandom % 8;
			sel  = (kind == 0) ? 3 + ($urandom % 13) : $urandom % num_slaves;
			off  = (kind == 1) ? 8 + ($urandom % 8) : $urandom % reg_count;
			send_cmd($urandom % 2, make_addr(sel, off), $urandom);
			if ($urandom % 4 == 0)
			begin
				@(posedge clk);
				#2;
			end
		end
		drain();
		assert (rsp_count == cmd_count)
		else
		begin
			$display("error: time %0t signal rsp_count expected %0d actual %0d",
				$time, cmd_count, rsp_count);
			errors++;
		end
		report_test("5 random traffic");

		$display("commands %0d, responses %0d, errors %0d", cmd_count, rsp_count, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
hw/apb_pkg.sv
hw/map_pkg.sv
hw/apb_queue.sv
hw/apb_regbank.sv
hw/apb_bus.sv
hw/apb_master.sv
hw/apb_subsys_top.sv
verif/tb_apb_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the APB subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module tb_apb_subsys -o sim_apb > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_apb > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log

grep -q "Something failed" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "Everything OK" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
